//--- play_pkg.sv
package play_pkg;

    // Octave field codes
    localparam logic [1:0] OCT_MID  = 2'b00;
    localparam logic [1:0] OCT_UP   = 2'b01;
    localparam logic [1:0] OCT_DOWN = 2'b10;

    typedef struct packed {
        logic [1:0] octave;
        // One-hot, bit 0 is C and bit 6 is B
        logic [6:0] keys;
    } note_fields_t;

    // Judge compares raw words, renderers look at the fields
    typedef union packed {
        logic [8:0]   raw;
        note_fields_t f;
    } note_t;

    // Eight characters, character 0 sits in bits 63:56
    typedef logic [63:0] row_text_t;

    localparam int CHART_LEN_DEF   = 64;
    localparam int LANE_ROWS_DEF   = 16;
    localparam int STEP_CYCLES_DEF = 8;
    localparam int COUNT_STEPS_DEF = 2;

    localparam logic [7:0] CH_HIT   = "#";
    localparam logic [7:0] CH_EMPTY = ".";
    localparam logic [7:0] CH_UP    = "+";
    localparam logic [7:0] CH_DOWN  = "-";
    localparam logic [7:0] CH_SPACE = " ";

    localparam int POINTS_PERFECT = 10;
    localparam int POINTS_GREAT   = 8;
    localparam int POINTS_GOOD    = 5;

    localparam int SCORE_W = 14;

endpackage

//--- chart_sequencer.sv
`timescale 1ns/1ns

module chart_sequencer #(
    parameter int CHART_LEN   = play_pkg::CHART_LEN_DEF,
    parameter int LANE_ROWS   = play_pkg::LANE_ROWS_DEF,
    parameter int STEP_CYCLES = play_pkg::STEP_CYCLES_DEF,
    parameter int COUNT_STEPS = play_pkg::COUNT_STEPS_DEF
) (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           chart_we,
    input  logic [$clog2(CHART_LEN)-1:0]   chart_addr,
    input  play_pkg::note_t                chart_note,
    input  logic [$clog2(CHART_LEN+1)-1:0] chart_len,
    output logic                           step,
    output logic [1:0]                     countdown,
    output logic                           playing,
    output logic                           done,
    output logic [$clog2(CHART_LEN)-1:0]   position,
    output play_pkg::note_t                cur_note,
    output play_pkg::note_t                window_notes [LANE_ROWS]
);
    import play_pkg::*;

    localparam int ADDR_W  = $clog2(CHART_LEN);
    localparam int LEN_W   = $clog2(CHART_LEN+1);
    localparam int STEP_W  = $clog2(STEP_CYCLES+1);
    localparam int DIGIT_W = $clog2(COUNT_STEPS+1);

    note_t              chart_mem [CHART_LEN];
    logic [STEP_W-1:0]  step_cnt;
    logic [DIGIT_W-1:0] digit_cnt;
    logic [ADDR_W-1:0]  win_base;
    logic               running;
    logic               idle;
    logic               last_step;

    assign running   = (countdown != 2'd0) || playing;
    assign idle      = !running;
    assign step      = running && (step_cnt == STEP_W'(STEP_CYCLES-1));
    assign last_step = (LEN_W'(position) + LEN_W'(1)) >= chart_len;

    // Chart is locked once the countdown begins
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CHART_LEN; i++) begin
                chart_mem[i] <= '0;
            end
        end else if (chart_we && idle) begin
            chart_mem[chart_addr] <= chart_note;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_cnt  <= '0;
            digit_cnt <= '0;
            countdown <= 2'd0;
            playing   <= 1'b0;
            done      <= 1'b0;
            position  <= '0;
        end else if (start && idle) begin
            step_cnt  <= '0;
            digit_cnt <= '0;
            countdown <= 2'd3;
            done      <= 1'b0;
            position  <= '0;
        end else if (running) begin
            step_cnt <= step ? '0 : step_cnt + STEP_W'(1);
            if (step && countdown != 2'd0) begin
                if (digit_cnt == DIGIT_W'(COUNT_STEPS-1)) begin
                    digit_cnt <= '0;
                    countdown <= countdown - 2'd1;
                    // Last digit hands over to play
                    if (countdown == 2'd1) begin
                        playing  <= 1'b1;
                        position <= '0;
                    end
                end else begin
                    digit_cnt <= digit_cnt + DIGIT_W'(1);
                end
            end else if (step && playing) begin
                if (last_step) begin
                    playing <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    position <= position + ADDR_W'(1);
                end
            end
        end
    end

    assign cur_note = chart_mem[position];

    // Keep the window inside the chart near its end
    assign win_base = (int'(position) + LANE_ROWS > CHART_LEN) ?
                      ADDR_W'(CHART_LEN - LANE_ROWS) : position;

    always_comb begin
        for (int r = 0; r < LANE_ROWS; r++) begin
            window_notes[r] = chart_mem[ADDR_W'(int'(win_base) + r)];
        end
    end

endmodule

//--- lane_row.sv
`timescale 1ns/1ns

module lane_row (
    input  logic                prog_clk,
    input  logic                rst,
    input  play_pkg::note_t     note,
    output play_pkg::row_text_t row_text
);
    import play_pkg::*;

    row_text_t row_next;

    always_comb begin
        row_next = '0;
        // Characters 0 to 6 are the keys C to B
        for (int k = 0; k < 7; k++) begin
            row_next[63-8*k -: 8] = note.f.keys[k] ? CH_HIT : CH_EMPTY;
        end
        case (note.f.octave)
            OCT_UP:   row_next[7:0] = CH_UP;
            OCT_DOWN: row_next[7:0] = CH_DOWN;
            default:  row_next[7:0] = CH_EMPTY;
        endcase
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            row_text <= {8{CH_SPACE}};
        end else begin
            row_text <= row_next;
        end
    end

endmodule

//--- field_composer.sv
`timescale 1ns/1ns

module field_composer #(
    parameter int LANE_ROWS = play_pkg::LANE_ROWS_DEF
) (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic [1:0]          countdown,
    input  logic                playing,
    input  logic                done,
    input  play_pkg::row_text_t rows [LANE_ROWS],
    input  play_pkg::note_t     cur_note,
    output play_pkg::row_text_t field_text [LANE_ROWS],
    output logic [7:0]          led
);
    import play_pkg::*;

    logic [1:0] countdown_d;
    logic       playing_d;
    logic       done_d;
    note_t      cur_note_d;
    logic [7:0] digit_ch;
    logic [7:0] led_next;

    // State delayed by one cycle so it lines up with the row registers
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            countdown_d <= 2'd0;
            playing_d   <= 1'b0;
            done_d      <= 1'b0;
            cur_note_d  <= '0;
        end else begin
            countdown_d <= countdown;
            playing_d   <= playing;
            done_d      <= done;
            cur_note_d  <= cur_note;
        end
    end

    assign digit_ch = "0" + 8'(countdown_d);

    always_comb begin
        led_next[0] = (cur_note_d.f.octave != OCT_MID);
        // C on the leftmost LED
        for (int k = 0; k < 7; k++) begin
            led_next[7-k] = cur_note_d.f.keys[k];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < LANE_ROWS; r++) begin
                field_text[r] <= {8{CH_SPACE}};
            end
            led <= 8'd0;
        end else begin
            for (int r = 0; r < LANE_ROWS; r++) begin
                if (countdown_d != 2'd0) begin
                    field_text[r] <= {8{digit_ch}};
                end else if (playing_d || done_d) begin
                    field_text[r] <= rows[r];
                end else begin
                    field_text[r] <= {8{CH_SPACE}};
                end
            end
            led <= playing_d ? led_next : 8'd0;
        end
    end

endmodule

//--- score_judge.sv
`timescale 1ns/1ns

module score_judge (
    input  logic                          prog_clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          step,
    input  logic                          playing,
    input  play_pkg::note_t               cur_note,
    input  play_pkg::note_t               keys,
    output logic [play_pkg::SCORE_W-1:0]  score
);
    import play_pkg::*;

    // hist[0] is one step back, hist[2] three steps back
    note_t              hist [3];
    logic [SCORE_W-1:0] points;

    always_comb begin
        if (cur_note.raw == 9'd0) begin
            points = '0;
        end else if (cur_note.raw == keys.raw || cur_note.raw == hist[0].raw) begin
            points = SCORE_W'(POINTS_PERFECT);
        end else if (cur_note.raw == hist[1].raw) begin
            points = SCORE_W'(POINTS_GREAT);
        end else if (cur_note.raw == hist[2].raw) begin
            points = SCORE_W'(POINTS_GOOD);
        end else begin
            points = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            for (int i = 0; i < 3; i++) begin
                hist[i] <= '0;
            end
        end else if (start && !playing) begin
            score <= '0;
            for (int i = 0; i < 3; i++) begin
                hist[i] <= '0;
            end
        end else if (step && playing) begin
            hist[0] <= keys;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
            score   <= score + points;
        end
    end

endmodule

//--- play_top.sv
`timescale 1ns/1ns

module play_top #(
    parameter int CHART_LEN   = play_pkg::CHART_LEN_DEF,
    parameter int LANE_ROWS   = play_pkg::LANE_ROWS_DEF,
    parameter int STEP_CYCLES = play_pkg::STEP_CYCLES_DEF,
    parameter int COUNT_STEPS = play_pkg::COUNT_STEPS_DEF
) (
    input  logic                           prog_clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           chart_we,
    input  logic [$clog2(CHART_LEN)-1:0]   chart_addr,
    input  play_pkg::note_t                chart_note,
    input  logic [$clog2(CHART_LEN+1)-1:0] chart_len,
    input  play_pkg::note_t                keys,
    output logic [1:0]                     countdown,
    output logic                           playing,
    output logic                           done,
    output logic [$clog2(CHART_LEN)-1:0]   position,
    output logic [play_pkg::SCORE_W-1:0]   score,
    output play_pkg::row_text_t            field_text [LANE_ROWS],
    output logic [7:0]                     led
);
    import play_pkg::*;

    logic      step;
    note_t     cur_note;
    note_t     window_notes [LANE_ROWS];
    row_text_t row_text [LANE_ROWS];

    chart_sequencer #(
        .CHART_LEN   (CHART_LEN),
        .LANE_ROWS   (LANE_ROWS),
        .STEP_CYCLES (STEP_CYCLES),
        .COUNT_STEPS (COUNT_STEPS)
    ) seq_inst (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .start        (start),
        .chart_we     (chart_we),
        .chart_addr   (chart_addr),
        .chart_note   (chart_note),
        .chart_len    (chart_len),
        .step         (step),
        .countdown    (countdown),
        .playing      (playing),
        .done         (done),
        .position     (position),
        .cur_note     (cur_note),
        .window_notes (window_notes)
    );

    // One renderer per visible row
    for (genvar r = 0; r < LANE_ROWS; r++) begin : g_row
        lane_row row_inst (
            .prog_clk (prog_clk),
            .rst      (rst),
            .note     (window_notes[r]),
            .row_text (row_text[r])
        );
    end

    field_composer #(
        .LANE_ROWS (LANE_ROWS)
    ) comp_inst (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .countdown  (countdown),
        .playing    (playing),
        .done       (done),
        .rows       (row_text),
        .cur_note   (cur_note),
        .field_text (field_text),
        .led        (led)
    );

    score_judge judge_inst (
        .prog_clk (prog_clk),
        .rst      (rst),
        .start    (start),
        .step     (step),
        .playing  (playing),
        .cur_note (cur_note),
        .keys     (keys),
        .score    (score)
    );

endmodule

//--- play_chk.sv
`timescale 1ns/1ns

module play_chk (
    input logic                         prog_clk,
    input logic                         rst,
    input logic                         start,
    input logic [1:0]                   countdown,
    input logic                         playing,
    input logic                         done,
    input logic [play_pkg::SCORE_W-1:0] score
);

    a_play_done_excl: assert property (@(posedge prog_clk) disable iff (rst)
        !(playing && done))
        else $error("playing and done are high together");

    a_no_play_in_count: assert property (@(posedge prog_clk) disable iff (rst)
        !(playing && countdown != 2'd0))
        else $error("playing is high while the countdown runs");

    // Only a start may bring the score down
    a_score_rises: assert property (@(posedge prog_clk) disable iff (rst)
        !$past(start) |-> score >= $past(score))
        else $error("score decreased without a start");

endmodule

bind play_top play_chk chk_inst (
    .prog_clk  (prog_clk),
    .rst       (rst),
    .start     (start),
    .countdown (countdown),
    .playing   (playing),
    .done      (done),
    .score     (score)
);

//--- tb_play.sv
`timescale 1ns/1ns

module tb_play;
    import play_pkg::*;

    localparam int LEN     = 64;
    localparam int ROWS    = 16;
    localparam int W_COUNT = 0;
    localparam int W_POS   = 1;
    localparam int W_DONE  = 2;

    logic               prog_clk;
    logic               rst;
    logic               start;
    logic               chart_we;
    logic [5:0]         chart_addr;
    note_t              chart_note;
    logic [6:0]         chart_len;
    note_t              keys;
    logic [1:0]         countdown;
    logic               playing;
    logic               done;
    logic [5:0]         position;
    logic [SCORE_W-1:0] score;
    row_text_t          field_text [ROWS];
    logic [7:0]         led;

    note_t       chart_model [LEN];
    logic [31:0] lfsr = 32'd77726;
    int          last_total;

    play_top #(
        .CHART_LEN   (LEN),
        .LANE_ROWS   (ROWS),
        .STEP_CYCLES (8),
        .COUNT_STEPS (2)
    ) play_top_inst (.*);

    initial begin
        prog_clk = 1'b0;
        forever #4 prog_clk = ~prog_clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // One key and a valid octave so never a rest
    task automatic random_note(output note_t n);
        logic [31:0] v;
        draw_bits(5, v);
        n.raw = {(v[4:3] == 2'b11) ? 2'b00 : v[4:3], 7'(32'd1 << (v[2:0] % 3'd7))};
    endtask

    function automatic row_text_t render_note(input note_t n);
        row_text_t t;
        t = '0;
        for (int k = 0; k < 7; k++) begin
            t = {t[55:0], (n.raw[k] ? "#" : ".")};
        end
        if (n.raw[8:7] == 2'b01) begin
            t = {t[55:0], "+"};
        end else if (n.raw[8:7] == 2'b10) begin
            t = {t[55:0], "-"};
        end else begin
            t = {t[55:0], "."};
        end
        return t;
    endfunction

    function automatic logic [7:0] led_of(input note_t n);
        return {n.raw[0], n.raw[1], n.raw[2], n.raw[3], n.raw[4], n.raw[5], n.raw[6],
                n.raw[8:7] != 2'b00};
    endfunction

    function automatic int grade(input note_t n, input note_t now, input note_t b1,
                                 input note_t b2, input note_t b3);
        if (n.raw == 9'd0) return 0;
        if (n.raw == now.raw || n.raw == b1.raw) return 10;
        if (n.raw == b2.raw) return 8;
        if (n.raw == b3.raw) return 5;
        return 0;
    endfunction

    task automatic wait_for_state(input int what, input int value, input string label);
        int  n;
        bit  hit;
        n = 0;
        hit = 1'b0;
        while (!hit) begin
            @(negedge prog_clk);
            n++;
            case (what)
                W_COUNT: hit = (int'(countdown) == value);
                W_POS:   hit = playing && (int'(position) == value);
                default: hit = done;
            endcase
            if (!hit && n >= 100) begin
                $display("Timed out waiting for %s", label);
                abort_run();
            end
        end
    endtask

    task automatic check_all_rows(input row_text_t exp, input string what);
        for (int r = 0; r < ROWS; r++) begin
            expect_equal(field_text[r], exp, $sformatf("%s row %0d", what, r));
        end
    endtask

    task automatic check_window(input int p);
        int base;
        base = (p + ROWS > LEN) ? LEN - ROWS : p;
        for (int r = 0; r < ROWS; r++) begin
            expect_equal(field_text[r], render_note(chart_model[base + r]),
                         $sformatf("row %0d at position %0d", r, p));
        end
        expect_equal(64'(led), 64'(led_of(chart_model[p])), $sformatf("led at position %0d", p));
    endtask

    task automatic test_reset_state();
        expect_equal(64'(countdown), 64'd0, "countdown after reset");
        expect_equal(64'(playing), 64'd0, "playing after reset");
        expect_equal(64'(done), 64'd0, "done after reset");
        expect_equal(64'(position), 64'd0, "position after reset");
        expect_equal(64'(score), 64'd0, "score after reset");
        expect_equal(64'(led), 64'd0, "led after reset");
        check_all_rows({8{CH_SPACE}}, "field after reset");
    endtask

    task automatic load_chart();
        note_t n;
        for (int a = 0; a < LEN; a++) begin
            random_note(n);
            chart_model[a] = n;
            @(posedge prog_clk);
            chart_we   <= 1'b1;
            chart_addr <= 6'(a);
            chart_note <= n;
        end
        @(posedge prog_clk);
        chart_we <= 1'b0;
    endtask

    // key_mode 1 plays scored key patterns and key_mode 2 writes during play with keys at rest
    task automatic play_chart(input int len, input int key_mode);
        logic [31:0] v;
        note_t       k;
        note_t       junk;
        note_t       h0;
        note_t       h1;
        note_t       h2;
        int          total;
        k = '0;
        h0 = '0;
        h1 = '0;
        h2 = '0;
        total = 0;
        @(posedge prog_clk);
        chart_len <= 7'(len);
        keys      <= '0;
        start     <= 1'b1;
        @(posedge prog_clk);
        start <= 1'b0;
        for (int d = 3; d >= 1; d--) begin
            wait_for_state(W_COUNT, d, "countdown digit");
            repeat (2) @(negedge prog_clk);
            expect_equal(64'(score), 64'd0, "score during countdown");
            check_all_rows({8{8'("0" + d)}}, "countdown field");
        end
        for (int p = 0; p < len; p++) begin
            wait_for_state(W_POS, p, "next position");
            @(posedge prog_clk);
            if (key_mode == 1) begin
                draw_bits(2, v);
                case (v[1:0])
                    2'd0: k = chart_model[p];
                    2'd1: begin
                        draw_bits(9, v);
                        k.raw = v[8:0];
                    end
                    2'd2: begin
                        // Early press graded from the history
                        draw_bits(2, v);
                        k = chart_model[p + 1 + int'(v[1:0] % 2'd3)];
                    end
                    default: ;
                endcase
            end
            keys <= k;
            if (key_mode == 2) begin
                random_note(junk);
                draw_bits(6, v);
                chart_we   <= 1'b1;
                chart_addr <= v[5:0];
                chart_note <= junk;
            end
            @(posedge prog_clk);
            chart_we <= 1'b0;
            @(negedge prog_clk);
            check_window(p);
            total += grade(chart_model[p], k, h0, h1, h2);
            h2 = h1;
            h1 = h0;
            h0 = k;
        end
        wait_for_state(W_DONE, 0, "done");
        expect_equal(64'(playing), 64'd0, "playing after last step");
        expect_equal(64'(position), 64'(len - 1), "position after last step");
        expect_equal(64'(score), 64'(total), "final score");
        last_total = total;
    endtask

    task automatic test_finish_hold(input int len);
        repeat (20) @(negedge prog_clk);
        expect_equal(64'(done), 64'd1, "done holds");
        expect_equal(64'(position), 64'(len - 1), "position holds");
        expect_equal(64'(score), 64'(last_total), "score holds");
        @(posedge prog_clk);
        start <= 1'b1;
        @(posedge prog_clk);
        start <= 1'b0;
        @(negedge prog_clk);
        expect_equal(64'(done), 64'd0, "done after start");
        expect_equal(64'(countdown), 64'd3, "countdown after start");
        expect_equal(64'(score), 64'd0, "score after start");
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        chart_we   = 1'b0;
        chart_addr = '0;
        chart_note = '0;
        chart_len  = '0;
        keys       = '0;
        last_total = 0;
        repeat (5) @(posedge prog_clk);
        rst <= 1'b0;
        @(negedge prog_clk);
        test_reset_state();
        load_chart();
        play_chart(24, 1);
        // Full length reaches the clamped window near the chart end
        play_chart(LEN, 2);
        play_chart(24, 1);
        test_finish_hold(24);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- list.f
play_pkg.sv
chart_sequencer.sv
lane_row.sv
field_composer.sv
score_judge.sv
play_top.sv
play_chk.sv
tb_play.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_play
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
